/* hdl/udpcom_pkg.sv */
// fixed 10-byte request and 12-byte reply, big-endian fields, 16-bit additive checksum, no options
package udpcom_pkg;

	// --------------------------------------------------
	// datagram layout
	// --------------------------------------------------
	localparam int RAM_AW = 11;
	localparam int CSUM_W = 16;

	localparam logic [15:0] REQ_BYTES  = 16'd10;
	localparam logic [15:0] RESP_BYTES = 16'd12;
	localparam logic [3:0]  REQ_LAST   = 4'(REQ_BYTES - 16'd1);
	localparam logic [3:0]  RESP_LAST  = 4'(RESP_BYTES - 16'd1);

	// checksum covers the bytes below these offsets
	localparam logic [3:0] REQ_SUM_END  = 4'd8;
	localparam logic [3:0] RESP_SUM_END = 4'd10;

	localparam logic [15:0] DGRAM_HDR = 16'hAA55;

	// opcodes, high byte of the command id
	localparam logic [7:0] OP_WRITE = 8'h01;
	localparam logic [7:0] OP_READ  = 8'h02;

	localparam logic [7:0] ST_OK  = 8'd0;
	localparam logic [7:0] ST_BAD = 8'd1;

	// --------------------------------------------------
	// register map
	// --------------------------------------------------
	localparam logic [7:0] REG_CONFIG     = 8'd0;
	localparam logic [7:0] REG_MOTOR_FREQ = 8'd1;
	localparam logic [7:0] REG_ANGLE_OFS  = 8'd2;
	localparam logic [7:0] REG_IP         = 8'd3;
	localparam logic [7:0] REG_DIST_MIN   = 8'd4;
	localparam logic [7:0] REG_DIST_MAX   = 8'd5;
	localparam logic [7:0] REG_FW_VER     = 8'd6;
	localparam logic [7:0] REG_COUNT      = 8'd7;

	localparam logic [15:0] RST_CONFIG     = 16'h0001;
	localparam logic [31:0] RST_MOTOR_FREQ = 32'h0258_0258;
	localparam logic [31:0] RST_IP         = 32'hC0A8_0164;
	localparam logic [31:0] RST_DIST_MAX   = 32'h0000_FFFF;
	localparam logic [31:0] FW_VERSION     = 32'h2504_1515;

	// paired registers, motor1 or offset1 in the high half
	typedef struct packed {
		logic [15:0] hi;
		logic [15:0] lo;
	} pair_half_t;

	typedef union packed {
		logic [31:0] raw;
		pair_half_t  half;
	} pair_word_u;

endpackage

/* hdl/udpcom_if.sv */
// command and reply buses inside the block only; no back-pressure except resp_pending

// --------------------------------------------------
// parser to bank, one command per cmd_valid pulse
// --------------------------------------------------
interface udpcom_cmd_if;
	logic        cmd_valid;
	logic [7:0]  cmd_op;
	logic [7:0]  cmd_index;
	logic [31:0] cmd_para;
	logic [15:0] cmd_id;

	modport parser (
		output cmd_valid,
		output cmd_op,
		output cmd_index,
		output cmd_para,
		output cmd_id
	);

	modport bank (
		input cmd_valid,
		input cmd_op,
		input cmd_index,
		input cmd_para,
		input cmd_id
	);
endinterface

// --------------------------------------------------
// bank to builder, pending level back to the parser
// --------------------------------------------------
interface udpcom_resp_if;
	logic        resp_valid;
	logic [15:0] resp_id;
	logic [7:0]  resp_status;
	logic [31:0] resp_data;
	logic        resp_pending;

	modport bank (
		output resp_valid,
		output resp_id,
		output resp_status,
		output resp_data
	);

	modport builder (
		input  resp_valid,
		input  resp_id,
		input  resp_status,
		input  resp_data,
		output resp_pending
	);

	modport parser (
		input resp_pending
	);
endinterface

/* hdl/udpcom_datagram_parser.sv */
// rx RAM needs one cycle read latency; a rxdone while busy or a reply is pending is dropped
module udpcom_datagram_parser (
	input  logic                          i_clk,
	input  logic                          i_rst,
	input  logic                          i_udp_rxdone,
	input  logic [15:0]                   i_udp_rxbyte_num,
	output logic                          o_udp_rxram_rden,
	output logic [udpcom_pkg::RAM_AW-1:0] o_udp_rxram_rdaddr,
	input  logic [7:0]                    i_udp_rxram_data,
	udpcom_cmd_if.parser                  cmd,
	udpcom_resp_if.parser                 resp
);

	logic                          r_active;
	logic [3:0]                    r_addr;
	logic                          r_data_vld;
	logic [3:0]                    r_data_idx;
	logic                          r_len_ok;
	logic [71:0]                   r_shift;
	logic [udpcom_pkg::CSUM_W-1:0] r_sum;
	logic                          w_start;
	logic [15:0]                   w_rx_csum;
	logic                          w_ok;

	// own cmd_valid covers the gap before the builder raises pending
	assign w_start = i_udp_rxdone && !r_active && !cmd.cmd_valid && !resp.resp_pending;

	assign o_udp_rxram_rdaddr = {{(udpcom_pkg::RAM_AW - 4){1'b0}}, r_addr};

	// low checksum byte is still on the RAM bus
	assign w_rx_csum = {r_shift[7:0], i_udp_rxram_data};
	assign w_ok = r_len_ok && (r_shift[71:56] == udpcom_pkg::DGRAM_HDR) && (w_rx_csum == r_sum);

	// --------------------------------------------------
	// read sequencing
	// --------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			r_active         <= 1'b0;
			o_udp_rxram_rden <= 1'b0;
			r_addr           <= '0;
			r_data_vld       <= 1'b0;
			cmd.cmd_valid    <= 1'b0;
		end else begin
			cmd.cmd_valid <= 1'b0;
			r_data_vld    <= o_udp_rxram_rden;
			if (w_start) begin
				r_active         <= 1'b1;
				o_udp_rxram_rden <= 1'b1;
				r_addr           <= '0;
			end else if (o_udp_rxram_rden) begin
				if (r_addr == udpcom_pkg::REQ_LAST) begin
					o_udp_rxram_rden <= 1'b0;
				end else begin
					r_addr <= r_addr + 4'd1;
				end
			end
			// last byte in, accept or drop silently
			if (r_data_vld && (r_data_idx == udpcom_pkg::REQ_LAST)) begin
				r_active      <= 1'b0;
				cmd.cmd_valid <= w_ok;
			end
		end
	end

	// --------------------------------------------------
	// byte capture and checksum
	// --------------------------------------------------
	always_ff @(posedge i_clk) begin
		r_data_idx <= r_addr;
		if (w_start) begin
			r_len_ok <= (i_udp_rxbyte_num == udpcom_pkg::REQ_BYTES);
			r_sum    <= '0;
		end
		if (r_data_vld) begin
			r_shift <= {r_shift[63:0], i_udp_rxram_data};
			if (r_data_idx < udpcom_pkg::REQ_SUM_END) begin
				r_sum <= r_sum + {{(udpcom_pkg::CSUM_W - 8){1'b0}}, i_udp_rxram_data};
			end
			if (r_data_idx == udpcom_pkg::REQ_LAST) begin
				cmd.cmd_id    <= r_shift[55:40];
				cmd.cmd_op    <= r_shift[55:48];
				cmd.cmd_index <= r_shift[47:40];
				cmd.cmd_para  <= r_shift[39:8];
			end
		end
	end

	a_rden_idle: assert property (@(posedge i_clk) disable iff (i_rst)
		!r_active |-> !o_udp_rxram_rden);

	// the bank takes exactly one command per datagram
	a_cmd_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
		cmd.cmd_valid |=> !cmd.cmd_valid);

endmodule

/* hdl/udpcom_param_bank.sv */
// takes every command in its arrival cycle; index 6 is read-only, config keeps only 16 bits
module udpcom_param_bank (
	input  logic          i_clk,
	input  logic          i_rst,
	udpcom_cmd_if.bank    cmd,
	udpcom_resp_if.bank   resp,
	output logic [15:0]   o_config_mode,
	output logic [15:0]   o_freq_motor1,
	output logic [15:0]   o_freq_motor2,
	output logic [15:0]   o_angle_offset1,
	output logic [15:0]   o_angle_offset2,
	output logic [31:0]   o_lidar_ip,
	output logic [31:0]   o_distance_min,
	output logic [31:0]   o_distance_max
);

	logic [15:0]            r_config;
	udpcom_pkg::pair_word_u r_motor;
	udpcom_pkg::pair_word_u r_angle;
	logic [31:0]            r_ip;
	logic [31:0]            r_dist_min;
	logic [31:0]            r_dist_max;
	logic                   w_wr_legal;
	logic                   w_rd_legal;
	logic [31:0]            w_wr_held;
	logic [31:0]            w_rd_val;

	// firmware word sits above all writable indexes
	assign w_wr_legal = (cmd.cmd_op == udpcom_pkg::OP_WRITE) &&
		(cmd.cmd_index < udpcom_pkg::REG_FW_VER);
	assign w_rd_legal = (cmd.cmd_op == udpcom_pkg::OP_READ) &&
		(cmd.cmd_index < udpcom_pkg::REG_COUNT);

	// value held after the write with config zero-extended
	assign w_wr_held = (cmd.cmd_index == udpcom_pkg::REG_CONFIG) ?
		{16'h0000, cmd.cmd_para[15:0]} : cmd.cmd_para;

	always_comb begin
		case (cmd.cmd_index)
			udpcom_pkg::REG_CONFIG:     w_rd_val = {16'h0000, r_config};
			udpcom_pkg::REG_MOTOR_FREQ: w_rd_val = r_motor.raw;
			udpcom_pkg::REG_ANGLE_OFS:  w_rd_val = r_angle.raw;
			udpcom_pkg::REG_IP:         w_rd_val = r_ip;
			udpcom_pkg::REG_DIST_MIN:   w_rd_val = r_dist_min;
			udpcom_pkg::REG_DIST_MAX:   w_rd_val = r_dist_max;
			udpcom_pkg::REG_FW_VER:     w_rd_val = udpcom_pkg::FW_VERSION;
			default:                    w_rd_val = '0;
		endcase
	end

	// --------------------------------------------------
	// configuration registers
	// --------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			r_config    <= udpcom_pkg::RST_CONFIG;
			r_motor.raw <= udpcom_pkg::RST_MOTOR_FREQ;
			r_angle.raw <= '0;
			r_ip        <= udpcom_pkg::RST_IP;
			r_dist_min  <= '0;
			r_dist_max  <= udpcom_pkg::RST_DIST_MAX;
		end else if (cmd.cmd_valid && w_wr_legal) begin
			case (cmd.cmd_index)
				udpcom_pkg::REG_CONFIG:     r_config    <= cmd.cmd_para[15:0];
				udpcom_pkg::REG_MOTOR_FREQ: r_motor.raw <= cmd.cmd_para;
				udpcom_pkg::REG_ANGLE_OFS:  r_angle.raw <= cmd.cmd_para;
				udpcom_pkg::REG_IP:         r_ip        <= cmd.cmd_para;
				udpcom_pkg::REG_DIST_MIN:   r_dist_min  <= cmd.cmd_para;
				default:                    r_dist_max  <= cmd.cmd_para;
			endcase
		end
	end

	// --------------------------------------------------
	// reply one cycle after the command
	// --------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			resp.resp_valid <= 1'b0;
		end else begin
			resp.resp_valid <= cmd.cmd_valid;
		end
	end

	always_ff @(posedge i_clk) begin
		if (cmd.cmd_valid) begin
			resp.resp_id <= cmd.cmd_id;
			if (w_wr_legal) begin
				resp.resp_status <= udpcom_pkg::ST_OK;
				resp.resp_data   <= w_wr_held;
			end else if (w_rd_legal) begin
				resp.resp_status <= udpcom_pkg::ST_OK;
				resp.resp_data   <= w_rd_val;
			end else begin
				resp.resp_status <= udpcom_pkg::ST_BAD;
				resp.resp_data   <= '0;
			end
		end
	end

	assign o_config_mode   = r_config;
	assign o_freq_motor1   = r_motor.half.hi;
	assign o_freq_motor2   = r_motor.half.lo;
	assign o_angle_offset1 = r_angle.half.hi;
	assign o_angle_offset2 = r_angle.half.lo;
	assign o_lidar_ip      = r_ip;
	assign o_distance_min  = r_dist_min;
	assign o_distance_max  = r_dist_max;

	// reply one cycle on, and a legal write reads back as the value it reported
	a_resp_follows: assert property (@(posedge i_clk) disable iff (i_rst)
		cmd.cmd_valid |=> resp.resp_valid &&
			(!$past(w_wr_legal) || (resp.resp_data == w_rd_val)));

endmodule

/* hdl/udpcom_response_builder.sv */
// one reply in flight; a reply arriving while busy is lost, so the parser must wait on pending
module udpcom_response_builder (
	input  logic                          i_clk,
	input  logic                          i_rst,
	udpcom_resp_if.builder                resp,
	input  logic                          i_udpcom_busy,
	output logic                          o_udp_send_req,
	input  logic [udpcom_pkg::RAM_AW-1:0] i_udp_txram_rdaddr,
	output logic [7:0]                    o_udp_txram_rddata
);

	logic                          r_fill;
	logic                          r_wait;
	logic [3:0]                    r_idx;
	logic [15:0]                   r_id;
	logic [7:0]                    r_status;
	logic [31:0]                   r_data;
	logic [udpcom_pkg::CSUM_W-1:0] r_sum;
	logic [7:0]                    r_buf [0:udpcom_pkg::RESP_BYTES-1];
	logic                          w_accept;
	logic [7:0]                    w_byte;

	assign w_accept = resp.resp_valid && !r_fill && !r_wait;

	// acceptance cycle included so the parser never sees a gap
	assign resp.resp_pending = r_fill || r_wait || resp.resp_valid;

	// reply bytes in wire order
	always_comb begin
		case (r_idx)
			4'd0:    w_byte = udpcom_pkg::DGRAM_HDR[15:8];
			4'd1:    w_byte = udpcom_pkg::DGRAM_HDR[7:0];
			4'd2:    w_byte = r_id[15:8];
			4'd3:    w_byte = r_id[7:0];
			4'd4:    w_byte = r_status;
			4'd5:    w_byte = 8'h00;
			4'd6:    w_byte = r_data[31:24];
			4'd7:    w_byte = r_data[23:16];
			4'd8:    w_byte = r_data[15:8];
			4'd9:    w_byte = r_data[7:0];
			4'd10:   w_byte = r_sum[15:8];
			default: w_byte = r_sum[7:0];
		endcase
	end

	// --------------------------------------------------
	// fill, then wait for the UDP core
	// --------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			r_fill         <= 1'b0;
			r_wait         <= 1'b0;
			r_idx          <= '0;
			o_udp_send_req <= 1'b0;
		end else begin
			o_udp_send_req <= 1'b0;
			if (w_accept) begin
				r_fill <= 1'b1;
				r_idx  <= '0;
			end else if (r_fill) begin
				if (r_idx == udpcom_pkg::RESP_LAST) begin
					r_fill <= 1'b0;
					r_wait <= 1'b1;
				end else begin
					r_idx <= r_idx + 4'd1;
				end
			end else if (r_wait && !i_udpcom_busy) begin
				r_wait         <= 1'b0;
				o_udp_send_req <= 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (w_accept) begin
			r_id     <= resp.resp_id;
			r_status <= resp.resp_status;
			r_data   <= resp.resp_data;
			r_sum    <= '0;
		end
		if (r_fill) begin
			r_buf[r_idx] <= w_byte;
			if (r_idx < udpcom_pkg::RESP_SUM_END) begin
				r_sum <= r_sum + {{(udpcom_pkg::CSUM_W - 8){1'b0}}, w_byte};
			end
		end
		// tx read port, addresses past the reply read as zero
		if (16'(i_udp_txram_rdaddr) < udpcom_pkg::RESP_BYTES) begin
			o_udp_txram_rddata <= r_buf[i_udp_txram_rdaddr[3:0]];
		end else begin
			o_udp_txram_rddata <= 8'h00;
		end
	end

	// busy is sampled the cycle before the pulse
	a_send_not_busy: assert property (@(posedge i_clk) disable iff (i_rst)
		$rose(o_udp_send_req) |-> !$past(i_udpcom_busy));

endmodule

/* hdl/udpcom_control.sv */
// command path only: no flash init, DDR, calibration, broadcast or time stamps
module udpcom_control (
	input  logic                          i_clk,
	input  logic                          i_rst,

	// udp receive side
	input  logic                          i_udp_rxdone,
	input  logic [15:0]                   i_udp_rxbyte_num,
	output logic                          o_udp_rxram_rden,
	output logic [udpcom_pkg::RAM_AW-1:0] o_udp_rxram_rdaddr,
	input  logic [7:0]                    i_udp_rxram_data,

	// udp transmit side
	input  logic                          i_udpcom_busy,
	output logic                          o_udp_send_req,
	input  logic [udpcom_pkg::RAM_AW-1:0] i_udp_txram_rdaddr,
	output logic [7:0]                    o_udp_txram_rddata,
	output logic [15:0]                   o_udp_txbyte_num,

	// lidar configuration
	output logic [15:0]                   o_config_mode,
	output logic [15:0]                   o_freq_motor1,
	output logic [15:0]                   o_freq_motor2,
	output logic [15:0]                   o_angle_offset1,
	output logic [15:0]                   o_angle_offset2,
	output logic [31:0]                   o_lidar_ip,
	output logic [31:0]                   o_distance_min,
	output logic [31:0]                   o_distance_max
);

	udpcom_cmd_if  u_cmd_if ();
	udpcom_resp_if u_resp_if ();

	// --------------------------------------------------
	// datagram in, command out
	// --------------------------------------------------
	udpcom_datagram_parser u_datagram_parser (
		.i_clk              (i_clk),
		.i_rst              (i_rst),
		.i_udp_rxdone       (i_udp_rxdone),
		.i_udp_rxbyte_num   (i_udp_rxbyte_num),
		.o_udp_rxram_rden   (o_udp_rxram_rden),
		.o_udp_rxram_rdaddr (o_udp_rxram_rdaddr),
		.i_udp_rxram_data   (i_udp_rxram_data),
		.cmd                (u_cmd_if.parser),
		.resp               (u_resp_if.parser)
	);

	udpcom_param_bank u_param_bank (
		.i_clk           (i_clk),
		.i_rst           (i_rst),
		.cmd             (u_cmd_if.bank),
		.resp            (u_resp_if.bank),
		.o_config_mode   (o_config_mode),
		.o_freq_motor1   (o_freq_motor1),
		.o_freq_motor2   (o_freq_motor2),
		.o_angle_offset1 (o_angle_offset1),
		.o_angle_offset2 (o_angle_offset2),
		.o_lidar_ip      (o_lidar_ip),
		.o_distance_min  (o_distance_min),
		.o_distance_max  (o_distance_max)
	);

	// --------------------------------------------------
	// reply out
	// --------------------------------------------------
	udpcom_response_builder u_response_builder (
		.i_clk              (i_clk),
		.i_rst              (i_rst),
		.resp               (u_resp_if.builder),
		.i_udpcom_busy      (i_udpcom_busy),
		.o_udp_send_req     (o_udp_send_req),
		.i_udp_txram_rdaddr (i_udp_txram_rdaddr),
		.o_udp_txram_rddata (o_udp_txram_rddata)
	);

	// every reply has the same length
	assign o_udp_txbyte_num = udpcom_pkg::RESP_BYTES;

endmodule

/* include/udpcom_tb_ref.svh */
// included inside the testbench module; one request in flight, model follows the register table
`ifndef UDPCOM_TB_REF_SVH
`define UDPCOM_TB_REF_SVH

// --------------------------------------------------
// request under construction and its predicted reply
// --------------------------------------------------
logic [7:0]  req_bytes [0:11];
logic [7:0]  exp_bytes [0:11];

// register model, firmware word is a constant
logic [31:0] model_reg [0:5];

// 16-bit additive sum of the first n bytes
function automatic logic [15:0] sum16(input logic [7:0] arr [0:11], input int n);
	logic [15:0] s;
	int          k;
	s = '0;
	for (k = 0; k < n; k++) begin
		s = s + {8'h00, arr[4'(k)]};
	end
	return s;
endfunction

function automatic void model_reset();
	model_reg[0] = {16'h0000, udpcom_pkg::RST_CONFIG};
	model_reg[1] = udpcom_pkg::RST_MOTOR_FREQ;
	model_reg[2] = 32'h0000_0000;
	model_reg[3] = udpcom_pkg::RST_IP;
	model_reg[4] = 32'h0000_0000;
	model_reg[5] = udpcom_pkg::RST_DIST_MAX;
endfunction

// csum_flip corrupts the checksum for discard tests
function automatic void build_request(input logic [7:0] op, input logic [7:0] idx,
	input logic [31:0] para, input logic [15:0] hdr, input logic [15:0] csum_flip);
	logic [15:0] csum;
	req_bytes[0]  = hdr[15:8];
	req_bytes[1]  = hdr[7:0];
	req_bytes[2]  = op;
	req_bytes[3]  = idx;
	req_bytes[4]  = para[31:24];
	req_bytes[5]  = para[23:16];
	req_bytes[6]  = para[15:8];
	req_bytes[7]  = para[7:0];
	req_bytes[10] = 8'h00;
	req_bytes[11] = 8'h00;
	csum          = sum16(req_bytes, 8) ^ csum_flip;
	req_bytes[8]  = csum[15:8];
	req_bytes[9]  = csum[7:0];
endfunction

// expected reply bytes, model updated on a legal write
function automatic void predict_reply(input logic [7:0] op, input logic [7:0] idx,
	input logic [31:0] para);
	logic [7:0]  status;
	logic [31:0] data;
	logic [15:0] csum;
	status = udpcom_pkg::ST_BAD;
	data   = 32'h0000_0000;
	if (op == udpcom_pkg::OP_WRITE && idx < udpcom_pkg::REG_FW_VER) begin
		if (idx == udpcom_pkg::REG_CONFIG) begin
			model_reg[0] = {16'h0000, para[15:0]};
		end else begin
			model_reg[idx[2:0]] = para;
		end
		status = udpcom_pkg::ST_OK;
		data   = model_reg[idx[2:0]];
	end else if (op == udpcom_pkg::OP_READ && idx == udpcom_pkg::REG_FW_VER) begin
		status = udpcom_pkg::ST_OK;
		data   = udpcom_pkg::FW_VERSION;
	end else if (op == udpcom_pkg::OP_READ && idx < udpcom_pkg::REG_FW_VER) begin
		status = udpcom_pkg::ST_OK;
		data   = model_reg[idx[2:0]];
	end
	exp_bytes[0]  = udpcom_pkg::DGRAM_HDR[15:8];
	exp_bytes[1]  = udpcom_pkg::DGRAM_HDR[7:0];
	exp_bytes[2]  = op;
	exp_bytes[3]  = idx;
	exp_bytes[4]  = status;
	exp_bytes[5]  = 8'h00;
	exp_bytes[6]  = data[31:24];
	exp_bytes[7]  = data[23:16];
	exp_bytes[8]  = data[15:8];
	exp_bytes[9]  = data[7:0];
	exp_bytes[10] = 8'h00;
	exp_bytes[11] = 8'h00;
	csum          = sum16(exp_bytes, 10);
	exp_bytes[10] = csum[15:8];
	exp_bytes[11] = csum[7:0];
endfunction

`endif

/* testbench/tb_udpcom_control.sv */
// drives one request at a time; rx RAM model has one cycle latency, busy held only in test 5
module tb_udpcom_control;

	localparam int REPLY_TIMEOUT = 400;
	localparam int QUIET_CYCLES  = 100;

	logic        clk;
	logic        rst;
	logic        rxdone;
	logic [15:0] rxbyte_num;
	logic        rxram_rden;
	logic [10:0] rxram_rdaddr;
	logic [7:0]  rxram_data = 8'h00;
	logic        busy;
	logic        send_req;
	logic [10:0] txram_rdaddr;
	logic [7:0]  txram_rddata;
	logic [15:0] txbyte_num;
	logic [15:0] config_mode;
	logic [15:0] freq_motor1;
	logic [15:0] freq_motor2;
	logic [15:0] angle_offset1;
	logic [15:0] angle_offset2;
	logic [31:0] lidar_ip;
	logic [31:0] distance_min;
	logic [31:0] distance_max;

	logic [7:0]  rx_ram [0:2047];
	logic [7:0]  got_bytes [0:11];
	string       reply_name;
	event        reply_done;
	integer      seed = 32'h4d4d;
	int          err_count = 0;
	int          check_count = 0;
	logic [31:0] rnd;
	int          hold;
	int          idx;
	int          i;

	`include "udpcom_tb_ref.svh"

	udpcom_control DUT (
		.i_clk              (clk),
		.i_rst              (rst),
		.i_udp_rxdone       (rxdone),
		.i_udp_rxbyte_num   (rxbyte_num),
		.o_udp_rxram_rden   (rxram_rden),
		.o_udp_rxram_rdaddr (rxram_rdaddr),
		.i_udp_rxram_data   (rxram_data),
		.i_udpcom_busy      (busy),
		.o_udp_send_req     (send_req),
		.i_udp_txram_rdaddr (txram_rdaddr),
		.o_udp_txram_rddata (txram_rddata),
		.o_udp_txbyte_num   (txbyte_num),
		.o_config_mode      (config_mode),
		.o_freq_motor1      (freq_motor1),
		.o_freq_motor2      (freq_motor2),
		.o_angle_offset1    (angle_offset1),
		.o_angle_offset2    (angle_offset2),
		.o_lidar_ip         (lidar_ip),
		.o_distance_min     (distance_min),
		.o_distance_max     (distance_max)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// rx RAM, data one cycle after rden
	always @(posedge clk) begin
		if (rxram_rden) begin
			rxram_data <= rx_ram[rxram_rdaddr];
		end
	end

	// --------------------------------------------------
	// checking
	// --------------------------------------------------
	task automatic check_value(input string name, input logic [31:0] exp_val,
		input logic [31:0] act_val);
		check_count++;
		if (exp_val !== act_val) begin
			$display("ERR %s expected %h actual %h", name, exp_val, act_val);
			err_count++;
		end
	endtask

	// every captured reply against the prediction
	initial begin
		int k;
		forever begin
			@(reply_done);
			for (k = 0; k < 12; k++) begin
				check_value($sformatf("%s byte %0d", reply_name, k),
					32'(exp_bytes[4'(k)]), 32'(got_bytes[4'(k)]));
			end
		end
	end

	task automatic check_outputs(input string name);
		check_value({name, " config_mode"}, 32'(model_reg[0][15:0]), 32'(config_mode));
		check_value({name, " freq_motor1"}, 32'(model_reg[1][31:16]), 32'(freq_motor1));
		check_value({name, " freq_motor2"}, 32'(model_reg[1][15:0]), 32'(freq_motor2));
		check_value({name, " angle_offset1"}, 32'(model_reg[2][31:16]), 32'(angle_offset1));
		check_value({name, " angle_offset2"}, 32'(model_reg[2][15:0]), 32'(angle_offset2));
		check_value({name, " lidar_ip"}, model_reg[3], lidar_ip);
		check_value({name, " distance_min"}, model_reg[4], distance_min);
		check_value({name, " distance_max"}, model_reg[5], distance_max);
	endtask

	// --------------------------------------------------
	// stimulus, all called 1 unit after a rising edge
	// --------------------------------------------------
	task automatic send_datagram(input logic [15:0] nbytes);
		int k;
		for (k = 0; k < 10; k++) begin
			rx_ram[11'(k)] = req_bytes[4'(k)];
		end
		rxbyte_num = nbytes;
		rxdone     = 1'b1;
		@(posedge clk);
		#1;
		rxdone = 1'b0;
	endtask

	task automatic get_reply(input string name);
		int k;
		int n;
		bit seen;
		seen = 1'b0;
		n    = 0;
		while (!seen && n < REPLY_TIMEOUT) begin
			@(posedge clk);
			#1;
			seen = send_req;
			n++;
		end
		if (!seen) begin
			$display("timeout: no send request for %s within %0d cycles", name, REPLY_TIMEOUT);
			err_count++;
		end else begin
			for (k = 0; k < 12; k++) begin
				txram_rdaddr = 11'(k);
				@(posedge clk);
				#1;
				got_bytes[4'(k)] = txram_rddata;
			end
			reply_name = name;
			-> reply_done;
			@(posedge clk);
			#1;
		end
	endtask

	task automatic run_command(input string name, input logic [7:0] op,
		input logic [7:0] reg_idx, input logic [31:0] para);
		build_request(op, reg_idx, para, udpcom_pkg::DGRAM_HDR, 16'h0000);
		predict_reply(op, reg_idx, para);
		send_datagram(udpcom_pkg::REQ_BYTES);
		get_reply(name);
	endtask

	task automatic expect_silence(input string name);
		int n;
		for (n = 0; n < QUIET_CYCLES; n++) begin
			@(posedge clk);
			#1;
			check_value({name, " send_req"}, 32'h0, 32'(send_req));
		end
	endtask

	initial begin
		rst          = 1'b1;
		rxdone       = 1'b0;
		rxbyte_num   = 16'h0000;
		busy         = 1'b0;
		txram_rdaddr = 11'h000;
		for (i = 0; i < 2048; i++) begin
			rx_ram[11'(i)] = 8'(i ^ (i >> 3));
		end
		model_reset();
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;

		// reset values and firmware word
		check_outputs("reset");
		run_command("read fw", udpcom_pkg::OP_READ, udpcom_pkg::REG_FW_VER, 32'h0);

		// write then read back every writable index
		for (idx = 0; idx < 6; idx++) begin
			rnd = $random(seed);
			run_command($sformatf("write idx %0d", idx), udpcom_pkg::OP_WRITE, 8'(idx), rnd);
			run_command($sformatf("read idx %0d", idx), udpcom_pkg::OP_READ, 8'(idx), 32'h0);
		end
		check_outputs("after writes");

		// error replies
		rnd = $random(seed);
		run_command("write fw", udpcom_pkg::OP_WRITE, udpcom_pkg::REG_FW_VER, rnd);
		run_command("read idx 7", udpcom_pkg::OP_READ, udpcom_pkg::REG_COUNT, 32'h0);
		run_command("unknown op", 8'h03, udpcom_pkg::REG_CONFIG, rnd);
		check_outputs("after errors");

		// silent discards, then a good request
		rnd = $random(seed);
		build_request(udpcom_pkg::OP_WRITE, udpcom_pkg::REG_IP, rnd,
			udpcom_pkg::DGRAM_HDR, 16'h0001);
		send_datagram(udpcom_pkg::REQ_BYTES);
		expect_silence("bad checksum");
		build_request(udpcom_pkg::OP_WRITE, udpcom_pkg::REG_IP, rnd, 16'hAA56, 16'h0000);
		send_datagram(udpcom_pkg::REQ_BYTES);
		expect_silence("bad header");
		build_request(udpcom_pkg::OP_WRITE, udpcom_pkg::REG_IP, rnd,
			udpcom_pkg::DGRAM_HDR, 16'h0000);
		send_datagram(16'd9);
		expect_silence("short count");
		run_command("after discard", udpcom_pkg::OP_WRITE, udpcom_pkg::REG_DIST_MIN, rnd);
		check_outputs("after discard");

		// back-pressure from the UDP core
		rnd  = $random(seed);
		hold = 20 + int'(rnd % 32'd41);
		busy = 1'b1;
		rnd  = $random(seed);
		build_request(udpcom_pkg::OP_WRITE, udpcom_pkg::REG_DIST_MAX, rnd,
			udpcom_pkg::DGRAM_HDR, 16'h0000);
		predict_reply(udpcom_pkg::OP_WRITE, udpcom_pkg::REG_DIST_MAX, rnd);
		send_datagram(udpcom_pkg::REQ_BYTES);
		for (i = 0; i < hold; i++) begin
			@(posedge clk);
			#1;
			check_value("busy send_req", 32'h0, 32'(send_req));
		end
		busy = 1'b0;
		get_reply("backpressure");
		check_outputs("backpressure");
		check_value("txbyte_num", 32'd12, 32'(txbyte_num));

		repeat (4) @(posedge clk);
		$display("checks %0d errors %0d", check_count, err_count);
		if (err_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* lidar_udpcom.f */
+incdir+include
hdl/udpcom_pkg.sv
hdl/udpcom_if.sv
hdl/udpcom_datagram_parser.sv
hdl/udpcom_param_bank.sv
hdl/udpcom_response_builder.sv
hdl/udpcom_control.sv
testbench/tb_udpcom_control.sv

/* build.sh */
#!/bin/sh
# compiles the testbench with Verilator, runs it into a log and checks the result

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module tb_udpcom_control \
	-f lidar_udpcom.f \
	-o tb_udpcom_control_sim
if [ $? -ne 0 ]; then
	echo "build.sh: verilator compile failed"
	exit 1
fi

./obj_dir/tb_udpcom_control_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "build.sh: simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
	echo "build.sh: failure reported in $LOG"
	exit 1
fi

exit 0
